//--- tx_engine_macros.svh
// transmit engine sizes, constants and descriptor field positions
`ifndef TX_ENGINE_MACROS_SVH
`define TX_ENGINE_MACROS_SVH

// 16 descriptor table entries
`define TX_TAG_W        4
`define TX_PKT_LEN      1024
`define TX_LEN_W        32
`define TX_RAM_ADDR_W   16
`define TX_DMA_ADDR_W   64
`define TX_QPN_W        24
// counters picked by the low bits of the source qpn
`define TX_MSN_QPS      16
// minimum gap between follow-on chunks
`define TX_PACE         4

// descriptor layout
`define TX_WQE_W        184
`define TX_WQE_LEN_LSB  0
`define TX_WQE_LADDR_LSB 32
`define TX_WQE_RADDR_LSB 96
`define TX_WQE_DQPN_LSB 160

`endif

//--- tx_engine_pkg.sv
// transmit engine field types and output payload types
`default_nettype none

`include "tx_engine_macros.svh"

package tx_engine_pkg;

    typedef logic [`TX_TAG_W-1:0]      tag_t;
    typedef logic [`TX_LEN_W-1:0]      len_t;
    typedef logic [`TX_RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [`TX_DMA_ADDR_W-1:0] dma_addr_t;
    typedef logic [`TX_QPN_W-1:0]      qpn_t;

    // 160-bit packet header, remote address on top
    typedef struct packed {
        dma_addr_t raddr;
        qpn_t      psn;
        qpn_t      msn;
        qpn_t      dst_qpn;
        qpn_t      src_qpn;
    } tx_hdr_t;

    typedef struct packed {
        dma_addr_t dma_addr;
        ram_addr_t ram_addr;
        len_t      len;
        tag_t      tag;
    } dma_req_t;

    typedef struct packed {
        ram_addr_t addr;
        len_t      len;
        tag_t      tag;
        tx_hdr_t   hdr;
    } tx_cmd_t;

endpackage

`default_nettype wire

//--- msn_counter_bank.sv
// message sequence counters, one per low source qpn value
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module msn_counter_bank (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           bump,
    input  logic [$clog2(`TX_MSN_QPS)-1:0] qp_sel,
    output tx_engine_pkg::qpn_t            msn
);

    tx_engine_pkg::qpn_t cnt [`TX_MSN_QPS];

    // current value, taken by the message being accepted
    assign msn = cnt[qp_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TX_MSN_QPS; i++) begin
                cnt[i] <= '0;
            end
        end else if (bump) begin
            cnt[qp_sel] <= cnt[qp_sel] + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- wqe_table.sv
// per-tag descriptor store with fetched flags and packet numbers
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module wqe_table (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      latch_en,
    input  tx_engine_pkg::tag_t       latch_tag,
    input  tx_engine_pkg::dma_addr_t  latch_laddr,
    input  tx_engine_pkg::dma_addr_t  latch_raddr,
    input  tx_engine_pkg::qpn_t       latch_dst_qpn,
    input  tx_engine_pkg::qpn_t       latch_src_qpn,
    input  tx_engine_pkg::qpn_t       latch_msn,
    input  tx_engine_pkg::len_t       latch_total_len,
    input  logic                      fetched_en,
    input  tx_engine_pkg::tag_t       fetched_tag,
    input  logic                      sent_en,
    output logic                      ready_flag,
    output tx_engine_pkg::tag_t       ready_tag,
    output tx_engine_pkg::len_t       ready_total_len,
    output tx_engine_pkg::qpn_t       ready_psn,
    output tx_engine_pkg::dma_addr_t  ready_raddr,
    output tx_engine_pkg::qpn_t       ready_dst_qpn,
    output tx_engine_pkg::qpn_t       ready_src_qpn,
    output tx_engine_pkg::qpn_t       ready_msn
);

    localparam int DEPTH = 1 << `TX_TAG_W;

    tx_engine_pkg::len_t      len_mem   [DEPTH];
    tx_engine_pkg::dma_addr_t raddr_mem [DEPTH];
    tx_engine_pkg::qpn_t      dqpn_mem  [DEPTH];
    tx_engine_pkg::qpn_t      sqpn_mem  [DEPTH];
    tx_engine_pkg::qpn_t      msn_mem   [DEPTH];
    tx_engine_pkg::qpn_t      psn_mem   [DEPTH];

    logic [DEPTH-1:0]    fetched;
    tx_engine_pkg::tag_t pend_tag;

    assign ready_flag      = fetched[pend_tag];
    assign ready_tag       = pend_tag;
    assign ready_total_len = len_mem[pend_tag];
    assign ready_psn       = psn_mem[pend_tag];
    assign ready_raddr     = raddr_mem[pend_tag];
    assign ready_dst_qpn   = dqpn_mem[pend_tag];
    assign ready_src_qpn   = sqpn_mem[pend_tag];
    assign ready_msn       = msn_mem[pend_tag];

    always_ff @(posedge clk) begin
        if (sent_en) begin
            psn_mem[pend_tag] <= psn_mem[pend_tag] + 1'b1;
        end
        // a fresh descriptor restarts its packet numbering
        if (latch_en) begin
            len_mem[latch_tag]   <= latch_total_len;
            raddr_mem[latch_tag] <= latch_raddr;
            dqpn_mem[latch_tag]  <= latch_dst_qpn;
            sqpn_mem[latch_tag]  <= latch_src_qpn;
            msn_mem[latch_tag]   <= latch_msn;
            psn_mem[latch_tag]   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetched  <= '0;
            pend_tag <= '0;
        end else begin
            if (sent_en) begin
                fetched[pend_tag] <= 1'b0;
            end
            if (fetched_en) begin
                fetched[fetched_tag] <= 1'b1;
                pend_tag             <= fetched_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- dma_segmenter.sv
// descriptor accept and split into paced packet-sized dma reads
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module dma_segmenter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`TX_WQE_W-1:0]           wqe_data,
    input  tx_engine_pkg::qpn_t            wqe_qpn,
    input  tx_engine_pkg::tag_t            wqe_id,
    input  logic                           wqe_valid,
    output logic                           wqe_ready,
    output tx_engine_pkg::dma_req_t        req_data,
    output logic                           req_valid,
    input  logic                           req_ready,
    input  logic                           dma_valid,
    output logic                           msn_bump,
    output logic [$clog2(`TX_MSN_QPS)-1:0] msn_qp_sel,
    input  tx_engine_pkg::qpn_t            msn,
    output logic                           latch_en,
    output tx_engine_pkg::tag_t            latch_tag,
    output tx_engine_pkg::dma_addr_t       latch_laddr,
    output tx_engine_pkg::dma_addr_t       latch_raddr,
    output tx_engine_pkg::qpn_t            latch_dst_qpn,
    output tx_engine_pkg::qpn_t            latch_src_qpn,
    output tx_engine_pkg::qpn_t            latch_msn,
    output tx_engine_pkg::len_t            latch_total_len
);

    localparam int PACE_W = $clog2(`TX_PACE + 1);
    localparam tx_engine_pkg::len_t PKT_LEN = `TX_PKT_LEN;

    tx_engine_pkg::len_t      wqe_len;
    tx_engine_pkg::dma_addr_t wqe_laddr;
    tx_engine_pkg::len_t      first_len;
    tx_engine_pkg::len_t      next_len;
    logic                     accept;
    logic                     issue_next;

    // message in progress
    logic                     rest_vld;
    tx_engine_pkg::len_t      rest_len;
    tx_engine_pkg::len_t      offset;
    tx_engine_pkg::dma_addr_t base_addr;
    tx_engine_pkg::tag_t      rest_tag;
    logic [PACE_W-1:0]        pace_cnt;
    tx_engine_pkg::ram_addr_t wr_ptr;

    assign wqe_len   = wqe_data[`TX_WQE_LEN_LSB +: `TX_LEN_W];
    assign wqe_laddr = wqe_data[`TX_WQE_LADDR_LSB +: `TX_DMA_ADDR_W];
    assign first_len = (wqe_len > PKT_LEN) ? PKT_LEN : wqe_len;
    assign next_len  = (rest_len > PKT_LEN) ? PKT_LEN : rest_len;

    // no new message while follow-on chunks are pending
    assign wqe_ready  = !rest_vld && req_ready;
    assign accept     = wqe_valid && wqe_ready;
    assign issue_next = rest_vld && !dma_valid && req_ready &&
                        (pace_cnt == PACE_W'(`TX_PACE));
    assign req_valid  = (accept && (wqe_len != '0)) || issue_next;

    assign msn_bump        = accept;
    assign msn_qp_sel      = wqe_qpn[$clog2(`TX_MSN_QPS)-1:0];
    assign latch_en        = accept;
    assign latch_tag       = wqe_id;
    assign latch_laddr     = wqe_laddr;
    assign latch_raddr     = wqe_data[`TX_WQE_RADDR_LSB +: `TX_DMA_ADDR_W];
    assign latch_dst_qpn   = wqe_data[`TX_WQE_DQPN_LSB +: `TX_QPN_W];
    assign latch_src_qpn   = wqe_qpn;
    assign latch_msn       = msn;
    assign latch_total_len = wqe_len;

    always_comb begin
        req_data.ram_addr = wr_ptr;
        if (rest_vld) begin
            req_data.dma_addr = base_addr + tx_engine_pkg::dma_addr_t'(offset);
            req_data.len      = next_len;
            req_data.tag      = rest_tag;
        end else begin
            req_data.dma_addr = wqe_laddr;
            req_data.len      = first_len;
            req_data.tag      = wqe_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rest_vld <= 1'b0;
            pace_cnt <= '0;
            wr_ptr   <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr   <= wr_ptr + tx_engine_pkg::ram_addr_t'(req_data.len);
                pace_cnt <= PACE_W'(1);
            end else if (pace_cnt != PACE_W'(`TX_PACE)) begin
                pace_cnt <= pace_cnt + 1'b1;
            end
            if (accept) begin
                rest_vld <= wqe_len > PKT_LEN;
            end else if (issue_next) begin
                rest_vld <= rest_len > PKT_LEN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rest_len  <= wqe_len - first_len;
            offset    <= first_len;
            base_addr <= wqe_laddr;
            rest_tag  <= wqe_id;
        end else if (issue_next) begin
            rest_len <= rest_len - next_len;
            offset   <= offset + next_len;
        end
    end

endmodule

`default_nettype wire

//--- tx_scheduler.sv
// one transmit command per fetched packet, owns the buffer read pointer
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tx_scheduler (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ready_flag,
    input  tx_engine_pkg::tag_t      ready_tag,
    input  tx_engine_pkg::len_t      ready_total_len,
    input  tx_engine_pkg::qpn_t      ready_psn,
    input  tx_engine_pkg::dma_addr_t ready_raddr,
    input  tx_engine_pkg::qpn_t      ready_dst_qpn,
    input  tx_engine_pkg::qpn_t      ready_src_qpn,
    input  tx_engine_pkg::qpn_t      ready_msn,
    output logic                     sent_en,
    output tx_engine_pkg::tx_cmd_t   cmd_data,
    output logic                     cmd_valid,
    input  logic                     cmd_ready
);

    localparam tx_engine_pkg::len_t PKT_LEN = `TX_PKT_LEN;

    tx_engine_pkg::len_t      done_len;
    tx_engine_pkg::len_t      rest_len;
    tx_engine_pkg::len_t      pkt_len;
    tx_engine_pkg::ram_addr_t rd_ptr;

    // earlier packets of the message were all full size
    assign done_len = tx_engine_pkg::len_t'(ready_psn) << $clog2(`TX_PKT_LEN);
    assign rest_len = ready_total_len - done_len;
    assign pkt_len  = (rest_len > PKT_LEN) ? PKT_LEN : rest_len;

    assign cmd_valid = ready_flag;
    assign sent_en   = ready_flag && cmd_ready;

    always_comb begin
        cmd_data.addr        = rd_ptr;
        cmd_data.len         = pkt_len;
        cmd_data.tag         = ready_tag;
        cmd_data.hdr.raddr   = ready_raddr;
        cmd_data.hdr.psn     = ready_psn;
        cmd_data.hdr.msn     = ready_msn;
        cmd_data.hdr.dst_qpn = ready_dst_qpn;
        cmd_data.hdr.src_qpn = ready_src_qpn;
    end

    // fetches land in the buffer in order, so reads follow the same walk
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (sent_en) begin
            rd_ptr <= rd_ptr + tx_engine_pkg::ram_addr_t'(pkt_len);
        end
    end

endmodule

`default_nettype wire

//--- skid_buffer.sv
// two-entry registered valid/ready slice for any payload type
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t tmp_data;
    logic     tmp_valid;
    logic     ready_early;
    logic     take_out;
    logic     take_tmp;
    logic     tmp_to_out;

    // keep accepting while the temp register is free to catch a stall
    assign ready_early = out_ready || (!tmp_valid && (!out_valid || !in_valid));

    always_comb begin
        take_out   = 1'b0;
        take_tmp   = 1'b0;
        tmp_to_out = 1'b0;
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                take_out = 1'b1;
            end else begin
                take_tmp = 1'b1;
            end
        end else if (out_ready) begin
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            in_ready <= ready_early;
            if (take_out) begin
                out_valid <= in_valid;
            end else if (tmp_to_out) begin
                out_valid <= tmp_valid;
            end
            if (take_tmp) begin
                tmp_valid <= in_valid;
            end else if (tmp_to_out) begin
                tmp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_out) begin
            out_data <= in_data;
        end else if (tmp_to_out) begin
            out_data <= tmp_data;
        end
        if (take_tmp) begin
            tmp_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- tx_engine.sv
// transmit engine top, segmenter and scheduler behind two output slices
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tx_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`TX_WQE_W-1:0]     wqe_data,
    input  tx_engine_pkg::qpn_t      wqe_qpn,
    input  tx_engine_pkg::tag_t      wqe_id,
    input  logic                     wqe_valid,
    output logic                     wqe_ready,
    output tx_engine_pkg::dma_addr_t dma_addr,
    output tx_engine_pkg::ram_addr_t dma_ram_addr,
    output tx_engine_pkg::len_t      dma_len,
    output tx_engine_pkg::tag_t      dma_tag,
    output logic                     dma_valid,
    input  logic                     dma_ready,
    input  tx_engine_pkg::tag_t      status_tag,
    input  logic                     status_valid,
    output tx_engine_pkg::ram_addr_t tx_addr,
    output tx_engine_pkg::len_t      tx_len,
    output tx_engine_pkg::tag_t      tx_tag,
    output tx_engine_pkg::tx_hdr_t   tx_hdr,
    output logic                     tx_valid,
    input  logic                     tx_ready
);

    tx_engine_pkg::dma_req_t  req_data;
    tx_engine_pkg::dma_req_t  req_out;
    logic                     req_valid;
    logic                     req_ready;
    tx_engine_pkg::tx_cmd_t   cmd_data;
    tx_engine_pkg::tx_cmd_t   cmd_out;
    logic                     cmd_valid;
    logic                     cmd_ready;

    logic                           msn_bump;
    logic [$clog2(`TX_MSN_QPS)-1:0] msn_qp_sel;
    tx_engine_pkg::qpn_t            msn;

    logic                     latch_en;
    tx_engine_pkg::tag_t      latch_tag;
    tx_engine_pkg::dma_addr_t latch_laddr;
    tx_engine_pkg::dma_addr_t latch_raddr;
    tx_engine_pkg::qpn_t      latch_dst_qpn;
    tx_engine_pkg::qpn_t      latch_src_qpn;
    tx_engine_pkg::qpn_t      latch_msn;
    tx_engine_pkg::len_t      latch_total_len;

    logic                     sent_en;
    logic                     ready_flag;
    tx_engine_pkg::tag_t      ready_tag;
    tx_engine_pkg::len_t      ready_total_len;
    tx_engine_pkg::qpn_t      ready_psn;
    tx_engine_pkg::dma_addr_t ready_raddr;
    tx_engine_pkg::qpn_t      ready_dst_qpn;
    tx_engine_pkg::qpn_t      ready_src_qpn;
    tx_engine_pkg::qpn_t      ready_msn;

    assign dma_addr     = req_out.dma_addr;
    assign dma_ram_addr = req_out.ram_addr;
    assign dma_len      = req_out.len;
    assign dma_tag      = req_out.tag;
    assign tx_addr      = cmd_out.addr;
    assign tx_len       = cmd_out.len;
    assign tx_tag       = cmd_out.tag;
    assign tx_hdr       = cmd_out.hdr;

    msn_counter_bank u_msn (
        .clk(clk), .rst(rst), .bump(msn_bump), .qp_sel(msn_qp_sel), .msn(msn)
    );

    dma_segmenter u_seg (
        .clk(clk), .rst(rst),
        .wqe_data(wqe_data), .wqe_qpn(wqe_qpn), .wqe_id(wqe_id),
        .wqe_valid(wqe_valid), .wqe_ready(wqe_ready),
        .req_data(req_data), .req_valid(req_valid), .req_ready(req_ready),
        .dma_valid(dma_valid),
        .msn_bump(msn_bump), .msn_qp_sel(msn_qp_sel), .msn(msn),
        .latch_en(latch_en), .latch_tag(latch_tag), .latch_laddr(latch_laddr),
        .latch_raddr(latch_raddr), .latch_dst_qpn(latch_dst_qpn),
        .latch_src_qpn(latch_src_qpn), .latch_msn(latch_msn),
        .latch_total_len(latch_total_len)
    );

    wqe_table u_table (
        .clk(clk), .rst(rst),
        .latch_en(latch_en), .latch_tag(latch_tag), .latch_laddr(latch_laddr),
        .latch_raddr(latch_raddr), .latch_dst_qpn(latch_dst_qpn),
        .latch_src_qpn(latch_src_qpn), .latch_msn(latch_msn),
        .latch_total_len(latch_total_len),
        .fetched_en(status_valid), .fetched_tag(status_tag), .sent_en(sent_en),
        .ready_flag(ready_flag), .ready_tag(ready_tag), .ready_total_len(ready_total_len),
        .ready_psn(ready_psn), .ready_raddr(ready_raddr), .ready_dst_qpn(ready_dst_qpn),
        .ready_src_qpn(ready_src_qpn), .ready_msn(ready_msn)
    );

    tx_scheduler u_sched (
        .clk(clk), .rst(rst),
        .ready_flag(ready_flag), .ready_tag(ready_tag), .ready_total_len(ready_total_len),
        .ready_psn(ready_psn), .ready_raddr(ready_raddr), .ready_dst_qpn(ready_dst_qpn),
        .ready_src_qpn(ready_src_qpn), .ready_msn(ready_msn), .sent_en(sent_en),
        .cmd_data(cmd_data), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready)
    );

    skid_buffer #(.payload_t(tx_engine_pkg::dma_req_t)) u_req_slice (
        .clk(clk), .rst(rst),
        .in_data(req_data), .in_valid(req_valid), .in_ready(req_ready),
        .out_data(req_out), .out_valid(dma_valid), .out_ready(dma_ready)
    );

    skid_buffer #(.payload_t(tx_engine_pkg::tx_cmd_t)) u_cmd_slice (
        .clk(clk), .rst(rst),
        .in_data(cmd_data), .in_valid(cmd_valid), .in_ready(cmd_ready),
        .out_data(cmd_out), .out_valid(tx_valid), .out_ready(tx_ready)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock source with a synchronous reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge so it never races the rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tx_engine_tb.sv
// transmit engine testbench with a descriptor table and a dma and status responder
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tx_engine_tb;

    localparam int ROWS    = 9;
    localparam int TIMEOUT = 5000;
    localparam logic [31:0] PKT = `TX_PKT_LEN;

    logic                     clk;
    logic                     rst;
    logic [`TX_WQE_W-1:0]     wqe_data;
    tx_engine_pkg::qpn_t      wqe_qpn;
    tx_engine_pkg::tag_t      wqe_id;
    logic                     wqe_valid;
    logic                     wqe_ready;
    tx_engine_pkg::dma_addr_t dma_addr;
    tx_engine_pkg::ram_addr_t dma_ram_addr;
    tx_engine_pkg::len_t      dma_len;
    tx_engine_pkg::tag_t      dma_tag;
    logic                     dma_valid;
    logic                     dma_ready;
    tx_engine_pkg::tag_t      status_tag;
    logic                     status_valid;
    tx_engine_pkg::ram_addr_t tx_addr;
    tx_engine_pkg::len_t      tx_len;
    tx_engine_pkg::tag_t      tx_tag;
    tx_engine_pkg::tx_hdr_t   tx_hdr;
    logic                     tx_valid;
    logic                     tx_ready;

    // one descriptor per row of length, source qpn, destination qpn, local, remote and tag
    logic [31:0] row_len [ROWS] = '{32'd3000, 32'd1, 32'd0, 32'd1024, 32'd1025,
                                    32'd2048, 32'd500, 32'd66000, 32'd1500};
    logic [23:0] row_sqpn [ROWS] = '{24'h000011, 24'h000021, 24'h000011, 24'h000011,
                                     24'h000032, 24'h000102, 24'h000011, 24'h0000a2,
                                     24'h000021};
    logic [23:0] row_dqpn [ROWS] = '{24'h0000a5, 24'h0000b0, 24'h0000a5, 24'h00c001,
                                     24'h00c002, 24'h00c003, 24'h0000b0, 24'h123456,
                                     24'hfedcba};
    logic [63:0] row_laddr [ROWS] = '{64'h0000_0010_0000_0000, 64'h0000_0010_0000_4000,
                                      64'h0000_0010_0000_8000, 64'h0000_0020_0000_0000,
                                      64'h0000_0020_0001_0000, 64'h0000_0030_0000_0400,
                                      64'h0000_0030_0010_0000, 64'h0000_0040_0000_0000,
                                      64'h0000_0050_0000_0200};
    logic [63:0] row_raddr [ROWS] = '{64'h8000_0000_0000_1000, 64'h8000_0000_0000_2000,
                                      64'h8000_0000_0000_3000, 64'h8000_0001_0000_0000,
                                      64'h8000_0002_0000_0000, 64'h8000_0003_0000_0000,
                                      64'h9000_0000_0000_0000, 64'h9000_0001_0000_0000,
                                      64'h9000_0002_0000_0000};
    logic [3:0]  row_tag [ROWS] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9};

    // reference model state
    logic [23:0]              msn_model [16] = '{default: '0};
    logic [15:0]              ram_ptr = '0;
    tx_engine_pkg::dma_req_t  exp_req_q [$];
    tx_engine_pkg::tx_cmd_t   exp_cmd_q [$];
    tx_engine_pkg::tag_t      stat_q [$];
    tx_engine_pkg::dma_req_t  req_exp;
    tx_engine_pkg::tx_cmd_t   cmd_exp;
    int                       accepted_cnt = 0;
    int                       req_seen = 0;
    int                       cmd_seen = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

    tx_engine u_dut (
        .clk(clk), .rst(rst),
        .wqe_data(wqe_data), .wqe_qpn(wqe_qpn), .wqe_id(wqe_id),
        .wqe_valid(wqe_valid), .wqe_ready(wqe_ready),
        .dma_addr(dma_addr), .dma_ram_addr(dma_ram_addr), .dma_len(dma_len),
        .dma_tag(dma_tag), .dma_valid(dma_valid), .dma_ready(dma_ready),
        .status_tag(status_tag), .status_valid(status_valid),
        .tx_addr(tx_addr), .tx_len(tx_len), .tx_tag(tx_tag), .tx_hdr(tx_hdr),
        .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    function automatic int total_chunks();
        int n;
        n = 0;
        for (int r = 0; r < ROWS; r++) begin
            n += int'((row_len[r] + PKT - 32'd1) / PKT);
        end
        return n;
    endfunction

    // expected requests and commands of one accepted descriptor
    task automatic model_accept(input int r);
        tx_engine_pkg::dma_req_t req;
        tx_engine_pkg::tx_cmd_t  cmd;
        logic [23:0]             msn;
        logic [31:0]             left;
        logic [31:0]             clen;
        int                      k;
        msn = msn_model[row_sqpn[r][3:0]];
        msn_model[row_sqpn[r][3:0]] = msn + 24'd1;
        left = row_len[r];
        k = 0;
        while (left != 0) begin
            clen = (left > PKT) ? PKT : left;
            req.dma_addr    = row_laddr[r] + 64'(k) * 64'(PKT);
            req.ram_addr    = ram_ptr;
            req.len         = clen;
            req.tag         = row_tag[r];
            cmd.addr        = ram_ptr;
            cmd.len         = clen;
            cmd.tag         = row_tag[r];
            cmd.hdr.raddr   = row_raddr[r];
            cmd.hdr.psn     = 24'(k);
            cmd.hdr.msn     = msn;
            cmd.hdr.dst_qpn = row_dqpn[r];
            cmd.hdr.src_qpn = row_sqpn[r];
            exp_req_q.push_back(req);
            exp_cmd_q.push_back(cmd);
            ram_ptr = ram_ptr + clen[15:0];
            left    = left - clen;
            k++;
        end
    endtask

    // all handshakes are sampled on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            // with wqe_ready high only the slice output may still hold a request
            if (wqe_ready && exp_req_q.size() > 1) begin
                fail_run("wqe_ready went high while chunks of a message were still pending");
            end
            if (wqe_valid && wqe_ready) begin
                model_accept(accepted_cnt);
                accepted_cnt++;
            end
            if (dma_valid && dma_ready) begin
                if (exp_req_q.size() == 0) begin
                    fail_run("DMA request seen when none was expected");
                end else begin
                    req_exp = exp_req_q.pop_front();
                    check_value($sformatf("req %0d dma_addr", req_seen), req_exp.dma_addr, dma_addr);
                    check_value($sformatf("req %0d ram_addr", req_seen), req_exp.ram_addr,
                                dma_ram_addr);
                    check_value($sformatf("req %0d len", req_seen), req_exp.len, dma_len);
                    check_value($sformatf("req %0d tag", req_seen), req_exp.tag, dma_tag);
                    stat_q.push_back(dma_tag);
                    req_seen++;
                end
            end
            if (tx_valid && tx_ready) begin
                if (exp_cmd_q.size() == 0) begin
                    fail_run("transmit command seen when none was expected");
                end else begin
                    cmd_exp = exp_cmd_q.pop_front();
                    check_value($sformatf("cmd %0d addr", cmd_seen), cmd_exp.addr, tx_addr);
                    check_value($sformatf("cmd %0d len", cmd_seen), cmd_exp.len, tx_len);
                    check_value($sformatf("cmd %0d tag", cmd_seen), cmd_exp.tag, tx_tag);
                    check_value($sformatf("cmd %0d hdr", cmd_seen), cmd_exp.hdr, tx_hdr);
                    cmd_seen++;
                end
            end
        end
    end

    // random back-pressure on both outputs
    initial begin
        int unsigned seed;
        seed = 32'h0399b639;
        dma_ready = 1'b0;
        tx_ready  = 1'b0;
        void'($urandom(seed));
        forever begin
            @(negedge clk);
            dma_ready = ($urandom % 4) != 0;
            tx_ready  = ($urandom % 3) != 0;
        end
    end

    // one fetch status pulse per request once the previous command went out
    initial begin
        int total;
        int cnt;
        status_tag   = '0;
        status_valid = 1'b0;
        total = total_chunks();
        for (int n = 0; n < total; n++) begin
            cnt = 0;
            while (stat_q.size() == 0) begin
                @(negedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_run("timeout waiting for a DMA request");
            end
            status_tag   = stat_q.pop_front();
            status_valid = 1'b1;
            @(negedge clk);
            status_valid = 1'b0;
            cnt = 0;
            while (cmd_seen <= n) begin
                @(negedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_run("timeout waiting for a transmit command");
            end
        end
    end

    initial begin
        int cnt;
        wqe_data  = '0;
        wqe_qpn   = '0;
        wqe_id    = '0;
        wqe_valid = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            if (rst) begin
                check_value("reset wqe_ready", 1'b0, wqe_ready);
                check_value("reset dma_valid", 1'b0, dma_valid);
                check_value("reset tx_valid", 1'b0, tx_valid);
            end
            cnt++;
            if (cnt > TIMEOUT) fail_run("timeout waiting for reset to end");
        end while (rst);

        for (int i = 0; i < ROWS; i++) begin
            wqe_data  = {row_dqpn[i], row_raddr[i], row_laddr[i], row_len[i]};
            wqe_qpn   = row_sqpn[i];
            wqe_id    = row_tag[i];
            wqe_valid = 1'b1;
            cnt = 0;
            while (accepted_cnt <= i) begin
                @(negedge clk);
                cnt++;
                if (cnt > TIMEOUT) fail_run("timeout waiting for a descriptor to be accepted");
            end
        end
        wqe_valid = 1'b0;

        cnt = 0;
        while (cmd_seen < total_chunks()) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_run("timeout waiting for the last transmit command");
        end
        // idle a little so a stray request or command would show up
        repeat (20) @(negedge clk);
        check_value("requests seen", total_chunks(), req_seen);
        check_value("commands seen", total_chunks(), cmd_seen);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
tx_engine_pkg.sv
msn_counter_bank.sv
wqe_table.sv
dma_segmenter.sv
tx_scheduler.sv
skid_buffer.sv
tx_engine.sv
tb_clock_gen.sv
tx_engine_tb.sv

//--- Makefile
TOP = tx_engine_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
